//--- hw/cache_pkg.sv
// Shared widths and line geometry for the direct-mapped write-back cache.
// A line is eight 32-bit words, moved as four 64-bit beats on the burst RAM.
// Byte offset bits of the processor address are ignored.

package cache_pkg;

  // processor data word, also used for the byte address
  typedef logic [31:0] word_t;

  // byte write strobe, all zeros means a read
  typedef logic [3:0] strobe_t;

  // one burst RAM data beat
  typedef logic [63:0] beat_t;

  // word position inside a cache line
  typedef logic [2:0] column_ix_t;

  // number of address bits that select the word in a line
  localparam int COLUMN_IX_W = 3;

  // byte offset bits below the column field
  localparam int ZEROS_W = 2;

  // words per line
  localparam int COLUMNS = 8;

  // 64-bit beats needed to move one line
  localparam int BEATS_PER_LINE = 4;

endpackage

//--- hw/byte_enable_ram.sv
// 32-bit wide RAM with per-byte write strobes.
// Read is asynchronous, write happens at the rising clock edge.
// Contents are undefined until written.

`timescale 1ns/1ps

module byte_enable_ram
  import cache_pkg::*;
#(
  parameter int addr_w = 8
) (
  input  logic              clk,
  input  strobe_t           we,
  input  logic [addr_w-1:0] addr,
  input  word_t             wdata,
  output word_t             rdata
);

  word_t mem [2**addr_w];

  always_ff @(posedge clk) begin
    for (int b = 0; b < 4; b++) begin
      if (we[b]) begin
        mem[addr][b*8 +: 8] <= wdata[b*8 +: 8];
      end
    end
  end

  assign rdata = mem[addr];

endmodule

//--- hw/tag_store.sv
// Tag, valid and dirty bits for each cache line, with hit detection.
// After reset a sweep clears one valid bit per cycle; hit stays low until it ends.
// Requires ram_addr_w no wider than the tag plus line index plus two.

`timescale 1ns/1ps

module tag_store
  import cache_pkg::*;
#(
  parameter int line_ix_w = 8,
  parameter int ram_addr_w = 12,
  localparam int tag_w = 32 - line_ix_w - COLUMN_IX_W - ZEROS_W
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [line_ix_w-1:0]  line_ix,
  input  logic [tag_w-1:0]      addr_tag,
  input  logic                  tag_fill,
  input  logic                  cpu_write,
  output logic                  hit,
  output logic                  dirty,
  output logic [ram_addr_w-1:0] wb_addr
);

  logic [tag_w-1:0]        tag_mem [2**line_ix_w];
  logic [2**line_ix_w-1:0] valid_bits;
  logic [2**line_ix_w-1:0] dirty_bits;
  logic [line_ix_w-1:0]    sweep_ix;
  logic                    sweeping;
  // beat address of the resident line, before truncation to the RAM size
  logic [tag_w+line_ix_w+$clog2(BEATS_PER_LINE)-1:0] wb_line_addr;

  always_ff @(posedge clk) begin
    if (rst) begin
      sweeping <= 1'b1;
      sweep_ix <= '0;
    end else if (sweeping) begin
      sweep_ix <= sweep_ix + 1'b1;
      if (&sweep_ix) begin
        sweeping <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (sweeping) begin
      valid_bits[sweep_ix] <= 1'b0;
    end
    // a freshly filled line matches the RAM, so it starts clean
    if (tag_fill) begin
      tag_mem[line_ix]    <= addr_tag;
      valid_bits[line_ix] <= 1'b1;
      dirty_bits[line_ix] <= 1'b0;
    end else if (cpu_write) begin
      dirty_bits[line_ix] <= 1'b1;
    end
  end

  assign hit   = !sweeping && valid_bits[line_ix] && (tag_mem[line_ix] == addr_tag);
  assign dirty = valid_bits[line_ix] && dirty_bits[line_ix];

  assign wb_line_addr = {tag_mem[line_ix], line_ix, {$clog2(BEATS_PER_LINE){1'b0}}};
  assign wb_addr      = wb_line_addr[ram_addr_w-1:0];

  // fills only happen on a miss and processor writes only on a hit
  a_fill_vs_write: assert property (@(posedge clk) disable iff (rst) !(tag_fill && cpu_write));

endmodule

//--- hw/line_store.sv
// Data storage of the cache: eight word-wide column RAMs indexed by line.
// A fill beat writes one column pair, a processor write one column.
// Both are never requested in the same cycle.

`timescale 1ns/1ps

module line_store
  import cache_pkg::*;
#(
  parameter int line_ix_w = 8
) (
  input  logic                 clk,
  input  logic [line_ix_w-1:0] line_ix,
  input  column_ix_t           column_ix,
  input  strobe_t              cpu_we,
  input  word_t                cpu_wdata,
  input  logic                 fill_we,
  input  logic [1:0]           fill_beat_ix,
  input  beat_t                fill_beat,
  output word_t                rdata,
  output word_t                line_words [COLUMNS]
);

  strobe_t col_we    [COLUMNS];
  word_t   col_wdata [COLUMNS];

  for (genvar c = 0; c < COLUMNS; c++) begin : g_column
    // beat n carries columns 2n (low half) and 2n+1 (high half)
    always_comb begin
      col_we[c]    = '0;
      col_wdata[c] = cpu_wdata;
      if (fill_we) begin
        if (fill_beat_ix == 2'(c / 2)) begin
          col_we[c] = '1;
        end
        col_wdata[c] = (c % 2 == 1) ? fill_beat[63:32] : fill_beat[31:0];
      end else if (column_ix == column_ix_t'(c)) begin
        col_we[c] = cpu_we;
      end
    end

    byte_enable_ram #(
      .addr_w(line_ix_w)
    ) column_ram (
      .clk  (clk),
      .we   (col_we[c]),
      .addr (line_ix),
      .wdata(col_wdata[c]),
      .rdata(line_words[c])
    );
  end

  assign rdata = line_words[column_ix];

  // the controller fills only while the processor is stalled on a miss
  a_no_mixed_write: assert property (@(posedge clk) !(fill_we && (cpu_we != '0)));

endmodule

//--- hw/burst_controller.sv
// Miss handling over the burst RAM: dirty write-back, then line fill.
// Commands are strobed for one cycle and only while br_busy is low.
// Read beats 2 to 4 must follow the ready beat on consecutive cycles.
// Write-back beats are taken from the line still resident at the address index.

`timescale 1ns/1ps

module burst_controller
  import cache_pkg::*;
#(
  parameter int ram_addr_w = 12
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  hit,
  input  logic                  dirty,
  input  logic [ram_addr_w-1:0] fill_addr,
  input  logic [ram_addr_w-1:0] wb_addr,
  input  word_t                 line_words [COLUMNS],
  input  logic                  br_busy,
  input  logic                  br_rd_data_ready,
  input  beat_t                 br_rd_data,
  output logic                  br_cmd,
  output logic                  br_cmd_en,
  output logic [ram_addr_w-1:0] br_addr,
  output beat_t                 br_wr_data,
  output logic                  fill_we,
  output logic [1:0]            fill_beat_ix,
  output beat_t                 fill_beat,
  output logic                  tag_fill
);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_WB_ISSUE,
    ST_WB_BEATS,
    ST_RD_ISSUE,
    ST_RD_WAIT,
    ST_FILL
  } burst_state_t;

  localparam logic [1:0] LAST_BEAT = 2'(BEATS_PER_LINE - 1);

  burst_state_t state;
  burst_state_t state_next;
  logic [1:0]   beat_cnt;
  logic         beat_step;

  always_comb begin
    state_next = state;
    beat_step  = 1'b0;
    br_cmd_en  = 1'b0;
    fill_we    = 1'b0;
    tag_fill   = 1'b0;
    case (state)
      ST_IDLE: begin
        if (!hit) begin
          state_next = dirty ? ST_WB_ISSUE : ST_RD_ISSUE;
        end
      end
      ST_WB_ISSUE: begin
        // first write beat goes out together with the command
        if (!br_busy) begin
          br_cmd_en  = 1'b1;
          beat_step  = 1'b1;
          state_next = ST_WB_BEATS;
        end
      end
      ST_WB_BEATS: begin
        beat_step = 1'b1;
        if (beat_cnt == LAST_BEAT) begin
          state_next = ST_RD_ISSUE;
        end
      end
      ST_RD_ISSUE: begin
        if (!br_busy) begin
          br_cmd_en  = 1'b1;
          state_next = ST_RD_WAIT;
        end
      end
      ST_RD_WAIT: begin
        if (br_rd_data_ready) begin
          fill_we    = 1'b1;
          beat_step  = 1'b1;
          state_next = ST_FILL;
        end
      end
      ST_FILL: begin
        fill_we   = 1'b1;
        beat_step = 1'b1;
        // tag goes valid with the last beat, so the hit shows up next cycle
        if (beat_cnt == LAST_BEAT) begin
          tag_fill   = 1'b1;
          state_next = ST_IDLE;
        end
      end
      default: begin
        state_next = ST_IDLE;
      end
    endcase
  end

  // beat_cnt wraps to zero after the last beat of every burst
  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= ST_IDLE;
      beat_cnt <= '0;
    end else begin
      state <= state_next;
      if (beat_step) begin
        beat_cnt <= beat_cnt + 1'b1;
      end
    end
  end

  assign br_cmd  = (state == ST_WB_ISSUE);
  assign br_addr = (state == ST_WB_ISSUE) ? wb_addr : fill_addr;

  // beat_cnt is still zero in the issue state, so it selects the first write beat there
  assign br_wr_data = {line_words[{beat_cnt, 1'b1}], line_words[{beat_cnt, 1'b0}]};

  // read beats go straight into the column RAMs
  assign fill_beat_ix = beat_cnt;
  assign fill_beat    = br_rd_data;

  // the RAM pulses ready only for a read burst that is being waited on
  a_ready_in_wait: assert property (@(posedge clk) disable iff (rst)
    br_rd_data_ready |-> (state == ST_RD_WAIT));

endmodule

//--- hw/cache_top.sv
// Direct-mapped write-back data cache in front of a 64-bit burst RAM.
// The processor holds address, data_in and write_enable stable while busy is high.
// Read data is valid in the same cycle as a hit; writes land at the edge where busy is low.
// Byte addresses must stay below 2^(ram_addr_w+3) or the RAM aliases.

`timescale 1ns/1ps

module cache_top
  import cache_pkg::*;
#(
  parameter int line_ix_w = 8,
  parameter int ram_addr_w = 12
) (
  input  logic                  clk,
  input  logic                  rst,
  input  word_t                 address,
  input  word_t                 data_in,
  input  strobe_t               write_enable,
  output word_t                 data_out,
  output logic                  data_out_ready,
  output logic                  busy,
  output logic                  br_cmd,
  output logic                  br_cmd_en,
  output logic [ram_addr_w-1:0] br_addr,
  output beat_t                 br_wr_data,
  input  beat_t                 br_rd_data,
  input  logic                  br_rd_data_ready,
  input  logic                  br_busy
);

  localparam int LINE_LSB = COLUMN_IX_W + ZEROS_W;
  localparam int TAG_LSB  = LINE_LSB + line_ix_w;

  // address fields: | tag | line | column | byte |
  column_ix_t           column_ix;
  logic [line_ix_w-1:0] line_ix;
  logic [31-TAG_LSB:0]  addr_tag;
  // line number times four gives the first beat of the line
  logic [31-LINE_LSB+$clog2(BEATS_PER_LINE):0] fill_line_addr;
  logic [ram_addr_w-1:0] fill_addr;
  logic [ram_addr_w-1:0] wb_addr;

  logic       hit;
  logic       dirty;
  strobe_t    cpu_we;
  logic       fill_we;
  logic [1:0] fill_beat_ix;
  beat_t      fill_beat;
  logic       tag_fill;
  word_t      line_words [COLUMNS];

  assign column_ix      = address[LINE_LSB-1:ZEROS_W];
  assign line_ix        = address[TAG_LSB-1:LINE_LSB];
  assign addr_tag       = address[31:TAG_LSB];
  assign fill_line_addr = {address[31:LINE_LSB], {$clog2(BEATS_PER_LINE){1'b0}}};
  assign fill_addr      = fill_line_addr[ram_addr_w-1:0];

  assign busy           = !hit;
  assign cpu_we         = hit ? write_enable : '0;
  assign data_out_ready = hit && (write_enable == '0);

  tag_store #(
    .line_ix_w (line_ix_w),
    .ram_addr_w(ram_addr_w)
  ) tag_store_inst (
    .clk      (clk),
    .rst      (rst),
    .line_ix  (line_ix),
    .addr_tag (addr_tag),
    .tag_fill (tag_fill),
    .cpu_write(cpu_we != '0),
    .hit      (hit),
    .dirty    (dirty),
    .wb_addr  (wb_addr)
  );

  line_store #(
    .line_ix_w(line_ix_w)
  ) line_store_inst (
    .clk         (clk),
    .line_ix     (line_ix),
    .column_ix   (column_ix),
    .cpu_we      (cpu_we),
    .cpu_wdata   (data_in),
    .fill_we     (fill_we),
    .fill_beat_ix(fill_beat_ix),
    .fill_beat   (fill_beat),
    .rdata       (data_out),
    .line_words  (line_words)
  );

  burst_controller #(
    .ram_addr_w(ram_addr_w)
  ) burst_controller_inst (
    .clk             (clk),
    .rst             (rst),
    .hit             (hit),
    .dirty           (dirty),
    .fill_addr       (fill_addr),
    .wb_addr         (wb_addr),
    .line_words      (line_words),
    .br_busy         (br_busy),
    .br_rd_data_ready(br_rd_data_ready),
    .br_rd_data      (br_rd_data),
    .br_cmd          (br_cmd),
    .br_cmd_en       (br_cmd_en),
    .br_addr         (br_addr),
    .br_wr_data      (br_wr_data),
    .fill_we         (fill_we),
    .fill_beat_ix    (fill_beat_ix),
    .fill_beat       (fill_beat),
    .tag_fill        (tag_fill)
  );

endmodule

//--- dv/burst_ram_model.sv
// Behavioral burst RAM with 64-bit beats, simulation only.
// Contents are preloaded by the testbench; rd_latency must be 1 or more.
// busy covers a burst in progress and a forced hold of hold_len cycles.

`timescale 1ns/1ps

module burst_ram_model
  import cache_pkg::*;
#(
  parameter int addr_w = 9
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              cmd,
  input  logic              cmd_en,
  input  logic [addr_w-1:0] addr,
  input  beat_t             wr_data,
  output beat_t             rd_data,
  output logic              rd_data_ready,
  output logic              busy,
  input  logic [3:0]        rd_latency,
  input  logic              hold_load,
  input  logic [7:0]        hold_len
);

  beat_t             mem [2**addr_w];
  logic [addr_w-1:0] wr_addr;
  logic [addr_w-1:0] rd_addr;
  logic [1:0]        wr_left;
  logic [3:0]        rd_wait;
  logic [2:0]        rd_left;
  logic [7:0]        hold_cnt;

  always @(posedge clk) begin
    if (rst) begin
      wr_left  <= '0;
      rd_wait  <= '0;
      rd_left  <= '0;
      hold_cnt <= '0;
    end else begin
      if (hold_load) begin
        hold_cnt <= hold_len;
      end else if (hold_cnt != 8'd0) begin
        hold_cnt <= hold_cnt - 8'd1;
      end
      // write burst: first beat with the command, three more after it
      if (cmd_en && cmd) begin
        mem[addr] <= wr_data;
        wr_addr   <= addr + 1'b1;
        wr_left   <= 2'd3;
      end else if (wr_left != 2'd0) begin
        mem[wr_addr] <= wr_data;
        wr_addr      <= wr_addr + 1'b1;
        wr_left      <= wr_left - 2'd1;
      end
      // read burst: wait, then four beats on back-to-back cycles
      if (cmd_en && !cmd) begin
        rd_addr <= addr;
        rd_wait <= rd_latency;
      end else if (rd_wait != 4'd0) begin
        rd_wait <= rd_wait - 4'd1;
        if (rd_wait == 4'd1) begin
          rd_left <= 3'd4;
        end
      end else if (rd_left != 3'd0) begin
        rd_addr <= rd_addr + 1'b1;
        rd_left <= rd_left - 3'd1;
      end
    end
  end

  // ready marks only the first beat
  assign rd_data_ready = (rd_left == 3'd4);
  assign rd_data       = mem[rd_addr];
  assign busy          = (hold_cnt != 8'd0) || (wr_left != 2'd0) ||
                         (rd_wait != 4'd0) || (rd_left != 3'd0);

endmodule

//--- dv/cache_tb.sv
// Testbench for the cache with line_ix_w 4 and a 512-beat burst RAM.
// Byte addresses in the table stay below 4096 so the RAM never aliases.
// Expected read data comes from a shadow copy of the RAM contents.

`timescale 1ns/1ps

module cache_tb
  import cache_pkg::*;
();

  localparam int LINE_IX_W  = 4;
  localparam int RAM_ADDR_W = 9;
  localparam int TIMEOUT    = 300;

  typedef struct packed {
    logic [3:0] test;
    word_t      addr;
    word_t      data;
    strobe_t    strb;
    logic [7:0] hold;
    logic       expect_hit;
  } op_t;

  logic                  clk;
  logic                  rst;
  word_t                 address;
  word_t                 data_in;
  strobe_t               write_enable;
  word_t                 data_out;
  logic                  data_out_ready;
  logic                  busy;
  logic                  br_cmd;
  logic                  br_cmd_en;
  logic [RAM_ADDR_W-1:0] br_addr;
  beat_t                 br_wr_data;
  beat_t                 br_rd_data;
  logic                  br_rd_data_ready;
  logic                  br_busy;
  logic [3:0]            rd_latency;
  logic                  hold_load;
  logic [7:0]            hold_len;

  logic [31:0] lfsr;
  word_t       shadow [2**(RAM_ADDR_W+1)];
  op_t         ops [$];
  string       test_names [6];
  int          errors;

  cache_top #(
    .line_ix_w (LINE_IX_W),
    .ram_addr_w(RAM_ADDR_W)
  ) cache_top_inst (
    .clk             (clk),
    .rst             (rst),
    .address         (address),
    .data_in         (data_in),
    .write_enable    (write_enable),
    .data_out        (data_out),
    .data_out_ready  (data_out_ready),
    .busy            (busy),
    .br_cmd          (br_cmd),
    .br_cmd_en       (br_cmd_en),
    .br_addr         (br_addr),
    .br_wr_data      (br_wr_data),
    .br_rd_data      (br_rd_data),
    .br_rd_data_ready(br_rd_data_ready),
    .br_busy         (br_busy)
  );

  burst_ram_model #(
    .addr_w(RAM_ADDR_W)
  ) ram_model (
    .clk          (clk),
    .rst          (rst),
    .cmd          (br_cmd),
    .cmd_en       (br_cmd_en),
    .addr         (br_addr),
    .wr_data      (br_wr_data),
    .rd_data      (br_rd_data),
    .rd_data_ready(br_rd_data_ready),
    .busy         (br_busy),
    .rd_latency   (rd_latency),
    .hold_load    (hold_load),
    .hold_len     (hold_len)
  );

  always #2 clk = ~clk;

  // one galois step per bit taken, with the taps of x^32 + x^22 + x^2 + x + 1
  function automatic logic [63:0] take_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v    = {v[62:0], lfsr[0]};
      lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
    end
    return v;
  endfunction

  function automatic word_t merge_bytes(input word_t old_w, input word_t new_w,
                                        input strobe_t strb);
    word_t w;
    w = old_w;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        w[b*8 +: 8] = new_w[b*8 +: 8];
      end
    end
    return w;
  endfunction

  task automatic add_op(input logic [3:0] test, input word_t addr, input word_t data,
                        input strobe_t strb, input logic [7:0] hold, input logic expect_hit);
    ops.push_back(op_t'{test, addr, data, strb, hold, expect_hit});
  endtask

  task automatic run_access(input op_t op, output word_t got, output logic got_ready,
                            output int lat, output logic timed_out);
    @(posedge clk);
    address      <= op.addr;
    data_in      <= op.data;
    write_enable <= op.strb;
    hold_load    <= (op.hold != 8'd0);
    hold_len     <= op.hold;
    rd_latency   <= 4'(take_bits(3)) + 4'd1;
    @(negedge clk);
    lat = 0;
    while (busy && lat < TIMEOUT) begin
      @(posedge clk);
      hold_load <= 1'b0;
      @(negedge clk);
      lat++;
    end
    timed_out = busy;
    got       = data_out;
    got_ready = data_out_ready;
    // a write lands on this edge
    @(posedge clk);
    write_enable <= '0;
    hold_load    <= 1'b0;
  endtask

  // commands must never go out while the RAM reports busy
  always @(negedge clk) begin
    if (!rst) begin
      assert (!(br_cmd_en && br_busy)) else begin
        $display("burst command issued while the RAM was busy at %0t", $time);
        errors++;
      end
    end
  end

  initial begin
    word_t             got;
    word_t             expected;
    logic              got_ready;
    logic              timed_out;
    int                lat;
    int                base_errors;
    int                tests_run;
    int                tests_failed;
    logic [63:0]       v;
    logic [RAM_ADDR_W:0] ix;

    clk          = 1'b0;
    rst          = 1'b1;
    address      = '0;
    data_in      = '0;
    write_enable = '0;
    rd_latency   = 4'd1;
    hold_load    = 1'b0;
    hold_len     = '0;
    errors       = 0;
    base_errors  = 0;
    tests_run    = 0;
    tests_failed = 0;
    lfsr         = 32'd11;

    for (int i = 0; i < 2**RAM_ADDR_W; i++) begin
      v                = take_bits(64);
      ram_model.mem[i] <= v;
      shadow[2*i]      = v[31:0];
      shadow[2*i+1]    = v[63:32];
    end

    test_names = '{"reset and first miss", "read hits", "partial-strobe writes",
                   "dirty eviction", "write miss on clean line", "back-pressure"};
    add_op(4'd1, 32'h000, 32'h0, 4'h0, 8'd0, 1'b0);
    for (int w = 1; w < COLUMNS; w++) begin
      add_op(4'd2, word_t'(w * 4), 32'h0, 4'h0, 8'd0, 1'b1);
    end
    add_op(4'd3, 32'h008, 32'hA1B2_C3D4, 4'b0011, 8'd0, 1'b1);
    add_op(4'd3, 32'h014, 32'h5566_7788, 4'b1000, 8'd0, 1'b1);
    add_op(4'd3, 32'h01C, 32'hDEAD_BEEF, 4'b1111, 8'd0, 1'b1);
    add_op(4'd3, 32'h008, 32'h0, 4'h0, 8'd0, 1'b1);
    add_op(4'd3, 32'h014, 32'h0, 4'h0, 8'd0, 1'b1);
    // same line index, other tag
    add_op(4'd4, 32'h200, 32'h0, 4'h0, 8'd0, 1'b0);
    add_op(4'd4, 32'h008, 32'h0, 4'h0, 8'd0, 1'b0);
    add_op(4'd4, 32'h014, 32'h0, 4'h0, 8'd0, 1'b1);
    add_op(4'd4, 32'h01C, 32'h0, 4'h0, 8'd0, 1'b1);
    add_op(4'd5, 32'h444, 32'h0102_0304, 4'b0101, 8'd0, 1'b0);
    add_op(4'd5, 32'h444, 32'h0, 4'h0, 8'd0, 1'b1);
    add_op(4'd5, 32'h440, 32'h0, 4'h0, 8'd0, 1'b1);
    add_op(4'd6, 32'h860, 32'h0, 4'h0, 8'd12, 1'b0);
    add_op(4'd6, 32'h87C, 32'h0, 4'h0, 8'd0, 1'b1);
    add_op(4'd6, 32'h440, 32'h0BAD_F00D, 4'b1111, 8'd0, 1'b1);
    add_op(4'd6, 32'hA40, 32'h0, 4'h0, 8'd6, 1'b0);
    add_op(4'd6, 32'h444, 32'h0, 4'h0, 8'd0, 1'b0);
    add_op(4'd6, 32'h440, 32'h0, 4'h0, 8'd0, 1'b1);

    repeat (16) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    assert (br_cmd_en == 1'b0) else begin
      $display("ERROR t=%0t br_cmd_en expected 0 got %b", $time, br_cmd_en);
      errors++;
    end

    foreach (ops[i]) begin
      run_access(ops[i], got, got_ready, lat, timed_out);
      if (timed_out) begin
        $display("busy stayed high for %0d cycles at address %h", lat, ops[i].addr);
        errors++;
        break;
      end
      ix = ops[i].addr[RAM_ADDR_W+2:2];
      if (ops[i].strb == '0) begin
        expected = shadow[ix];
        assert (got == expected) else begin
          $display("ERROR t=%0t data_out expected %h got %h", $time, expected, got);
          errors++;
        end
        assert (got_ready) else begin
          $display("ERROR t=%0t data_out_ready expected 1 got %b", $time, got_ready);
          errors++;
        end
      end else begin
        // a write never reports read data
        assert (!got_ready) else begin
          $display("ERROR t=%0t data_out_ready expected 0 got %b", $time, got_ready);
          errors++;
        end
        shadow[ix] = merge_bytes(shadow[ix], ops[i].data, ops[i].strb);
      end
      if (ops[i].expect_hit) begin
        assert (lat == 0) else begin
          $display("access to %h stalled %0d cycles instead of hitting", ops[i].addr, lat);
          errors++;
        end
      end else begin
        assert (lat > int'(ops[i].hold)) else begin
          $display("access to %h finished after %0d cycles, too early for a miss",
                   ops[i].addr, lat);
          errors++;
        end
      end
      if (i == ops.size() - 1 || ops[i+1].test != ops[i].test) begin
        tests_run++;
        if (errors != base_errors) begin
          tests_failed++;
        end
        $display("test %0d %s: %s", ops[i].test, test_names[int'(ops[i].test) - 1],
                 (errors == base_errors) ? "ok" : "failed");
        base_errors = errors;
      end
    end

    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

//--- compile.f
hw/cache_pkg.sv
hw/byte_enable_ram.sv
hw/tag_store.sv
hw/line_store.sv
hw/burst_controller.sv
hw/cache_top.sv
dv/burst_ram_model.sv
dv/cache_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= cache_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Simulation FAILED" $(LOG); then \
		echo "run failed, see $(LOG)"; exit 1; \
	elif ! grep -q "Simulation PASSED" $(LOG); then \
		echo "run ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
